//--- source/hmac_param_pkg.sv
package hmac_param_pkg;

  // --------------------------------------------------
  // data path sizes
  // --------------------------------------------------
  localparam int data_width = 32;
  localparam int block_size = 1024;
  localparam int key_size   = 512;
  localparam int tag_size   = 512;
  localparam int seed_size  = 384;

  localparam int block_dwords = block_size / data_width;
  localparam int key_dwords   = key_size / data_width;
  localparam int tag_dwords   = tag_size / data_width;
  localparam int seed_dwords  = seed_size / data_width;

  // mode bit values
  localparam logic mode_384 = 1'b0;
  localparam logic mode_512 = 1'b1;

  // tag and key words that carry data in 384 mode
  localparam int dwords_384 = 12;

  typedef logic [data_width-1:0] dword_t;

  // word 0 of each array sits in the top bits
  typedef struct packed {
    logic                  init;
    logic                  next;
    logic                  mode;
    logic                  zeroize;
    logic [seed_size-1:0]  seed;
    logic [key_size-1:0]   key;
    logic [block_size-1:0] block;
  } core_req_t;

  typedef struct packed {
    logic                ready;
    logic                tag_valid;
    logic [tag_size-1:0] tag;
  } core_rsp_t;

endpackage

//--- source/hmac_reg_pkg.sv
package hmac_reg_pkg;

  import hmac_param_pkg::*;

  localparam int reg_addr_width = 12;

  // --------------------------------------------------
  // register byte offsets
  // --------------------------------------------------
  localparam logic [reg_addr_width-1:0] name0_offset    = 12'h000;
  localparam logic [reg_addr_width-1:0] name1_offset    = 12'h004;
  localparam logic [reg_addr_width-1:0] version0_offset = 12'h008;
  localparam logic [reg_addr_width-1:0] version1_offset = 12'h00C;
  localparam logic [reg_addr_width-1:0] ctrl_offset     = 12'h010;
  localparam logic [reg_addr_width-1:0] status_offset   = 12'h018;
  localparam logic [reg_addr_width-1:0] key_base        = 12'h040;
  localparam logic [reg_addr_width-1:0] block_base      = 12'h080;
  localparam logic [reg_addr_width-1:0] tag_base        = 12'h100;
  localparam logic [reg_addr_width-1:0] seed_base       = 12'h140;
  localparam logic [reg_addr_width-1:0] intr_en_offset  = 12'h200;
  localparam logic [reg_addr_width-1:0] intr_sts_offset = 12'h204;
  localparam logic [reg_addr_width-1:0] intr_glb_offset = 12'h208;

  // ctrl and status bits
  localparam int ctrl_init_bit    = 0;
  localparam int ctrl_next_bit    = 1;
  localparam int ctrl_zeroize_bit = 2;
  localparam int ctrl_mode_bit    = 3;
  localparam int status_ready_bit = 0;
  localparam int status_valid_bit = 1;

  // identity words, low half at the lower offset
  localparam logic [63:0] core_name    = 64'h3231_352d_6361_6d68;
  localparam logic [63:0] core_version = 64'h0000_0001_0000_0002;

  // --------------------------------------------------
  // write command to the operand stores
  // --------------------------------------------------
  localparam int wr_offset_width = $clog2(block_dwords);

  typedef enum logic [1:0] {
    region_key,
    region_block,
    region_seed
  } wr_region_e;

  typedef struct packed {
    logic                       valid;
    logic [wr_offset_width-1:0] offset;
    wr_region_e                 region;
    dword_t                     data;
  } wr_cmd_t;

endpackage

//--- source/hmac_reg_file.sv
`timescale 1ns/1ps

module hmac_reg_file
  import hmac_param_pkg::*;
  import hmac_reg_pkg::*;
#(
  parameter int addr_width = 32
) (
  input  logic                  clk,
  input  logic                  reset_n,
  input  logic                  cs,
  input  logic                  we,
  input  logic [addr_width-1:0] address,
  input  dword_t                write_data,
  output dword_t                read_data,
  output wr_cmd_t               wr_cmd,
  output logic                  init_pulse,
  output logic                  next_pulse,
  output logic                  zeroize_pulse,
  output logic                  mode,
  input  logic                  ready_q,
  input  logic                  valid,
  input  dword_t                tag_words [tag_dwords],
  input  dword_t                block_words [block_dwords],
  input  dword_t                seed_words [seed_dwords],
  output logic                  intr_en_wr,
  output logic                  intr_clr_wr,
  input  logic                  intr_en,
  input  logic                  intr_sts,
  input  logic                  notif_intr
);

  logic [reg_addr_width-1:0] addr;
  logic                      wr_req;
  logic                      rd_req;
  logic                      key_hit;
  logic                      block_hit;
  logic                      tag_hit;
  logic                      seed_hit;
  logic                      ctrl_wr;
  dword_t                    rd_word;

  assign addr   = address[reg_addr_width-1:0];
  assign wr_req = cs & we;
  assign rd_req = cs & ~we;

  // --------------------------------------------------
  // address decode
  // --------------------------------------------------
  // each array base is aligned to its own span
  assign key_hit   = addr[11:6] == key_base[11:6];
  assign block_hit = addr[11:7] == block_base[11:7];
  assign tag_hit   = addr[11:6] == tag_base[11:6];
  assign seed_hit  = (addr[11:6] == seed_base[11:6]) && (addr[5:2] < seed_dwords);

  assign ctrl_wr     = wr_req && (addr == ctrl_offset);
  assign intr_en_wr  = wr_req && (addr == intr_en_offset);
  assign intr_clr_wr = wr_req && (addr == intr_sts_offset);

  // word writes into key, block and seed arrays
  always_comb begin
    wr_cmd       = '0;
    wr_cmd.data  = write_data;
    wr_cmd.valid = wr_req && (key_hit || block_hit || seed_hit);
    if (block_hit) begin
      wr_cmd.region = region_block;
      wr_cmd.offset = addr[6:2];
    end else if (seed_hit) begin
      wr_cmd.region = region_seed;
      wr_cmd.offset = {1'b0, addr[5:2]};
    end else begin
      wr_cmd.region = region_key;
      wr_cmd.offset = {1'b0, addr[5:2]};
    end
  end

  // --------------------------------------------------
  // ctrl word
  // --------------------------------------------------
  // commands and mode only land while the core is idle, zeroize always does
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      init_pulse    <= 1'b0;
      next_pulse    <= 1'b0;
      zeroize_pulse <= 1'b0;
      mode          <= mode_384;
    end else begin
      init_pulse    <= ctrl_wr & ready_q & write_data[ctrl_init_bit];
      next_pulse    <= ctrl_wr & ready_q & write_data[ctrl_next_bit];
      zeroize_pulse <= ctrl_wr & write_data[ctrl_zeroize_bit];
      if (zeroize_pulse) begin
        mode <= mode_384;
      end else if (ctrl_wr && ready_q) begin
        mode <= write_data[ctrl_mode_bit];
      end
    end
  end

  // --------------------------------------------------
  // read path
  // --------------------------------------------------
  // key words never read back, they fall to the default zero
  always_comb begin
    rd_word = '0;
    if (block_hit) begin
      rd_word = block_words[addr[6:2]];
    end else if (tag_hit) begin
      rd_word = tag_words[addr[5:2]];
    end else if (seed_hit) begin
      rd_word = seed_words[addr[5:2]];
    end else begin
      case (addr)
        name0_offset:    rd_word = core_name[31:0];
        name1_offset:    rd_word = core_name[63:32];
        version0_offset: rd_word = core_version[31:0];
        version1_offset: rd_word = core_version[63:32];
        ctrl_offset:     rd_word[ctrl_mode_bit] = mode;
        status_offset: begin
          rd_word[status_ready_bit] = ready_q;
          rd_word[status_valid_bit] = valid;
        end
        intr_en_offset:  rd_word[0] = intr_en;
        intr_sts_offset: rd_word[0] = intr_sts;
        intr_glb_offset: rd_word[0] = notif_intr;
        default:         rd_word = '0;
      endcase
    end
  end

  // data shows the cycle after the strobe and holds until the next read
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      read_data <= '0;
    end else if (rd_req) begin
      read_data <= rd_word;
    end
  end

endmodule

//--- source/hmac_msg_store.sv
`timescale 1ns/1ps

module hmac_msg_store
  import hmac_param_pkg::*;
  import hmac_reg_pkg::*;
(
  input  logic                  clk,
  input  logic                  reset_n,
  input  wr_cmd_t               wr_cmd,
  input  logic                  zeroize,
  input  logic                  mode,
  output logic [key_size-1:0]   key,
  output logic [block_size-1:0] block,
  output logic [seed_size-1:0]  seed,
  output dword_t                block_words [block_dwords],
  output dword_t                seed_words [seed_dwords]
);

  dword_t key_words [key_dwords];

  // --------------------------------------------------
  // word storage
  // --------------------------------------------------
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      for (int i = 0; i < key_dwords; i++) begin
        key_words[i] <= '0;
      end
      for (int i = 0; i < block_dwords; i++) begin
        block_words[i] <= '0;
      end
      for (int i = 0; i < seed_dwords; i++) begin
        seed_words[i] <= '0;
      end
    end else if (zeroize) begin
      for (int i = 0; i < key_dwords; i++) begin
        key_words[i] <= '0;
      end
      for (int i = 0; i < block_dwords; i++) begin
        block_words[i] <= '0;
      end
      for (int i = 0; i < seed_dwords; i++) begin
        seed_words[i] <= '0;
      end
    end else if (wr_cmd.valid) begin
      case (wr_cmd.region)
        region_key:   key_words[wr_cmd.offset[3:0]] <= wr_cmd.data;
        region_block: block_words[wr_cmd.offset] <= wr_cmd.data;
        region_seed:  seed_words[wr_cmd.offset[3:0]] <= wr_cmd.data;
        default:      ;
      endcase
    end
  end

  // --------------------------------------------------
  // operand buses, word 0 first
  // --------------------------------------------------
  always_comb begin
    for (int i = 0; i < key_dwords; i++) begin
      // upper key words are hidden from the core in 384 mode
      if (mode == mode_384 && i >= dwords_384) begin
        key[key_size-1-i*data_width -: data_width] = '0;
      end else begin
        key[key_size-1-i*data_width -: data_width] = key_words[i];
      end
    end
    for (int i = 0; i < block_dwords; i++) begin
      block[block_size-1-i*data_width -: data_width] = block_words[i];
    end
    for (int i = 0; i < seed_dwords; i++) begin
      seed[seed_size-1-i*data_width -: data_width] = seed_words[i];
    end
  end

endmodule

//--- source/hmac_tag_capture.sv
`timescale 1ns/1ps

module hmac_tag_capture
  import hmac_param_pkg::*;
(
  input  logic      clk,
  input  logic      reset_n,
  input  logic      zeroize,
  input  logic      mode,
  input  core_rsp_t core_rsp,
  output dword_t    tag_words [tag_dwords],
  output logic      valid,
  output logic      ready_q,
  output logic      cmd_done
);

  logic tag_valid_q;

  // rising edge of tag_valid ends a command
  assign cmd_done = core_rsp.tag_valid & ~tag_valid_q;

  // edge detector keeps tracking the core through zeroize
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      tag_valid_q <= 1'b0;
    end else begin
      tag_valid_q <= core_rsp.tag_valid;
    end
  end

  // --------------------------------------------------
  // status flags
  // --------------------------------------------------
  // valid sets on the edge and holds while the core keeps tag_valid
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      ready_q <= 1'b0;
      valid   <= 1'b0;
    end else if (zeroize) begin
      ready_q <= 1'b0;
      valid   <= 1'b0;
    end else begin
      ready_q <= core_rsp.ready;
      valid   <= core_rsp.tag_valid & (valid | cmd_done);
    end
  end

  // --------------------------------------------------
  // tag words
  // --------------------------------------------------
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      for (int i = 0; i < tag_dwords; i++) begin
        tag_words[i] <= '0;
      end
    end else if (zeroize) begin
      for (int i = 0; i < tag_dwords; i++) begin
        tag_words[i] <= '0;
      end
    end else if (cmd_done) begin
      for (int i = 0; i < tag_dwords; i++) begin
        // only 12 words carry a 384 tag
        if (mode != mode_512 && i >= dwords_384) begin
          tag_words[i] <= '0;
        end else begin
          tag_words[i] <= core_rsp.tag[tag_size-1-i*data_width -: data_width];
        end
      end
    end
  end

endmodule

//--- source/hmac_intr.sv
`timescale 1ns/1ps

module hmac_intr
  import hmac_param_pkg::*;
(
  input  logic   clk,
  input  logic   reset_n,
  input  logic   zeroize,
  input  logic   cmd_done,
  input  dword_t write_data,
  input  logic   intr_en_wr,
  input  logic   intr_clr_wr,
  output logic   intr_en,
  output logic   intr_sts,
  output logic   notif_intr
);

  // --------------------------------------------------
  // cmd done notification
  // --------------------------------------------------
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      intr_en <= 1'b0;
    end else if (intr_en_wr) begin
      intr_en <= write_data[0];
    end
  end

  // a new completion wins over a clear in the same cycle
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      intr_sts <= 1'b0;
    end else if (zeroize) begin
      intr_sts <= 1'b0;
    end else if (cmd_done) begin
      intr_sts <= 1'b1;
    end else if (intr_clr_wr && write_data[0]) begin
      intr_sts <= 1'b0;
    end
  end

  // global line, one cycle behind the status
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      notif_intr <= 1'b0;
    end else begin
      notif_intr <= intr_sts & intr_en;
    end
  end

endmodule

//--- source/hmac_wrapper.sv
`timescale 1ns/1ps

module hmac_wrapper
  import hmac_param_pkg::*;
  import hmac_reg_pkg::*;
#(
  parameter int addr_width = 32
) (
  input  logic                  clk,
  input  logic                  reset_n,
  input  logic                  cs,
  input  logic                  we,
  input  logic [addr_width-1:0] address,
  input  dword_t                write_data,
  output dword_t                read_data,
  output core_req_t             core_req,
  input  core_rsp_t             core_rsp,
  output logic                  busy,
  output logic                  notif_intr
);

  wr_cmd_t               wr_cmd;
  logic                  init_pulse;
  logic                  next_pulse;
  logic                  zeroize_pulse;
  logic                  mode;
  logic                  ready_q;
  logic                  valid;
  logic                  cmd_done;
  logic                  intr_en_wr;
  logic                  intr_clr_wr;
  logic                  intr_en;
  logic                  intr_sts;
  logic [key_size-1:0]   core_key;
  logic [block_size-1:0] core_block;
  logic [seed_size-1:0]  core_seed;
  dword_t                tag_words [tag_dwords];
  dword_t                block_words [block_dwords];
  dword_t                seed_words [seed_dwords];

  // --------------------------------------------------
  // host registers
  // --------------------------------------------------
  hmac_reg_file #(
    .addr_width (addr_width)
  ) u_reg_file (
    .clk           (clk),
    .reset_n       (reset_n),
    .cs            (cs),
    .we            (we),
    .address       (address),
    .write_data    (write_data),
    .read_data     (read_data),
    .wr_cmd        (wr_cmd),
    .init_pulse    (init_pulse),
    .next_pulse    (next_pulse),
    .zeroize_pulse (zeroize_pulse),
    .mode          (mode),
    .ready_q       (ready_q),
    .valid         (valid),
    .tag_words     (tag_words),
    .block_words   (block_words),
    .seed_words    (seed_words),
    .intr_en_wr    (intr_en_wr),
    .intr_clr_wr   (intr_clr_wr),
    .intr_en       (intr_en),
    .intr_sts      (intr_sts),
    .notif_intr    (notif_intr)
  );

  hmac_msg_store u_msg_store (
    .clk         (clk),
    .reset_n     (reset_n),
    .wr_cmd      (wr_cmd),
    .zeroize     (zeroize_pulse),
    .mode        (mode),
    .key         (core_key),
    .block       (core_block),
    .seed        (core_seed),
    .block_words (block_words),
    .seed_words  (seed_words)
  );

  // --------------------------------------------------
  // core side
  // --------------------------------------------------
  always_comb begin
    core_req         = '0;
    core_req.init    = init_pulse;
    core_req.next    = next_pulse;
    core_req.mode    = mode;
    core_req.zeroize = zeroize_pulse;
    core_req.seed    = core_seed;
    core_req.key     = core_key;
    core_req.block   = core_block;
  end

  assign busy = ~core_rsp.ready;

  hmac_tag_capture u_tag_capture (
    .clk       (clk),
    .reset_n   (reset_n),
    .zeroize   (zeroize_pulse),
    .mode      (mode),
    .core_rsp  (core_rsp),
    .tag_words (tag_words),
    .valid     (valid),
    .ready_q   (ready_q),
    .cmd_done  (cmd_done)
  );

  hmac_intr u_intr (
    .clk         (clk),
    .reset_n     (reset_n),
    .zeroize     (zeroize_pulse),
    .cmd_done    (cmd_done),
    .write_data  (write_data),
    .intr_en_wr  (intr_en_wr),
    .intr_clr_wr (intr_clr_wr),
    .intr_en     (intr_en),
    .intr_sts    (intr_sts),
    .notif_intr  (notif_intr)
  );

endmodule

//--- tests/hmac_core_model.sv
`timescale 1ns/1ps

module hmac_core_model
  import hmac_param_pkg::*;
#(
  parameter int latency = 20
) (
  input  logic      clk,
  input  logic      reset_n,
  input  core_req_t core_req,
  output core_rsp_t core_rsp
);

  logic [7:0]          count;
  logic [tag_size-1:0] pending;

  // tag word i is key i ^ block i ^ block i+16, plus the old tag on next
  function automatic logic [tag_size-1:0] rule_tag(core_req_t req, logic [tag_size-1:0] prev,
                                                   logic use_prev);
    logic [tag_size-1:0] t;
    dword_t              w;
    for (int i = 0; i < tag_dwords; i++) begin
      w = req.key[key_size-1-i*data_width -: data_width] ^
          req.block[block_size-1-i*data_width -: data_width] ^
          req.block[block_size-1-(i+16)*data_width -: data_width];
      if (use_prev) begin
        w = w ^ prev[tag_size-1-i*data_width -: data_width];
      end
      t[tag_size-1-i*data_width -: data_width] = w;
    end
    return t;
  endfunction

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      core_rsp <= '0;
      core_rsp.ready <= 1'b1;
      count <= '0;
      pending <= '0;
    end else if (core_req.zeroize) begin
      core_rsp <= '0;
      core_rsp.ready <= 1'b1;
      count <= '0;
      pending <= '0;
    end else if (count == 0) begin
      if (core_req.init || core_req.next) begin
        pending <= rule_tag(core_req, core_rsp.tag, core_req.next);
        core_rsp.ready <= 1'b0;
        core_rsp.tag_valid <= 1'b0;
        count <= 8'(latency);
      end
    end else begin
      count <= count - 1'b1;
      // last busy cycle, result goes out
      if (count == 1) begin
        core_rsp.ready <= 1'b1;
        core_rsp.tag_valid <= 1'b1;
        core_rsp.tag <= pending;
      end
    end
  end

endmodule

//--- tests/hmac_wrapper_tb.sv
`timescale 1ns/1ps

module hmac_wrapper_tb
  import hmac_param_pkg::*;
  import hmac_reg_pkg::*;
();

  typedef enum logic [2:0] {
    op_write,
    op_read,
    op_wait_busy,
    op_wait_valid,
    op_check_irq,
    op_check_busy
  } op_e;

  typedef struct packed {
    op_e                       op;
    logic [reg_addr_width-1:0] addr;
    dword_t                    data;
    dword_t                    exp;
  } entry_t;

  localparam dword_t go_init_512 = (1 << ctrl_init_bit) | (1 << ctrl_mode_bit);
  localparam dword_t go_init_384 = 1 << ctrl_init_bit;
  localparam dword_t go_next_384 = 1 << ctrl_next_bit;
  localparam dword_t go_zeroize  = 1 << ctrl_zeroize_bit;

  logic        clk;
  logic        reset_n;
  logic        cs;
  logic        we;
  logic [31:0] address;
  dword_t      write_data;
  dword_t      read_data;
  core_req_t   core_req;
  core_rsp_t   core_rsp;
  logic        busy;
  logic        notif_intr;

  integer seed;
  bit     table_done;
  entry_t ent_q[$];
  string  name_q[$];
  dword_t key_w [key_dwords];
  dword_t blk_w [block_dwords];
  dword_t prev_w [tag_dwords];
  dword_t cur_w [tag_dwords];

  hmac_wrapper #(
    .addr_width (32)
  ) u_dut (
    .clk        (clk),
    .reset_n    (reset_n),
    .cs         (cs),
    .we         (we),
    .address    (address),
    .write_data (write_data),
    .read_data  (read_data),
    .core_req   (core_req),
    .core_rsp   (core_rsp),
    .busy       (busy),
    .notif_intr (notif_intr)
  );

  hmac_core_model #(
    .latency (20)
  ) u_core (
    .clk      (clk),
    .reset_n  (reset_n),
    .core_req (core_req),
    .core_rsp (core_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // --------------------------------------------------
  // table building
  // --------------------------------------------------
  function automatic void add_entry(string name, op_e op, int addr, dword_t data, dword_t exp);
    entry_t e;
    e.op   = op;
    e.addr = addr[reg_addr_width-1:0];
    e.data = data;
    e.exp  = exp;
    ent_q.push_back(e);
    name_q.push_back(name);
  endfunction

  function automatic void load_key(string tname);
    for (int i = 0; i < key_dwords; i++) begin
      key_w[i] = $random(seed);
      add_entry($sformatf("%s key%0d", tname, i), op_write, key_base + i * 4, key_w[i], 0);
    end
  endfunction

  function automatic void load_block(string tname);
    for (int i = 0; i < block_dwords; i++) begin
      blk_w[i] = $random(seed);
      add_entry($sformatf("%s blk%0d", tname, i), op_write, block_base + i * 4, blk_w[i], 0);
    end
  endfunction

  // ctrl write, then wait for the core to go busy and to finish
  function automatic void start_op(string tname, dword_t ctrl);
    add_entry(tname, op_write, ctrl_offset, ctrl, 0);
    add_entry({tname, " busy"}, op_wait_busy, status_offset, 0, 0);
    add_entry({tname, " busy high"}, op_check_busy, 0, 0, 32'h1);
    add_entry({tname, " valid"}, op_wait_valid, status_offset, 0, 0);
    add_entry({tname, " busy low"}, op_check_busy, 0, 0, 32'h0);
  endfunction

  // expected tag, key words 12 to 15 hidden in 384 mode
  function automatic void compute_tag(bit use_prev, logic mode_bit);
    dword_t key_term;
    for (int i = 0; i < tag_dwords; i++) begin
      key_term = key_w[i];
      if (mode_bit == mode_384 && i >= dwords_384) begin
        key_term = '0;
      end
      cur_w[i] = key_term ^ blk_w[i] ^ blk_w[i + block_dwords / 2];
      if (use_prev) begin
        cur_w[i] = cur_w[i] ^ prev_w[i];
      end
    end
    prev_w = cur_w;
  endfunction

  function automatic void add_tag_reads(string tname, int last);
    for (int i = 0; i < tag_dwords; i++) begin
      add_entry($sformatf("%s tag%0d", tname, i), op_read, tag_base + i * 4, 0,
                (i < last) ? cur_w[i] : 32'h0);
    end
  endfunction

  function automatic void build_table();
    dword_t seed_val [seed_dwords];
    add_entry("name0", op_read, name0_offset, 0, core_name[31:0]);
    add_entry("name1", op_read, name1_offset, 0, core_name[63:32]);
    add_entry("version0", op_read, version0_offset, 0, core_version[31:0]);
    add_entry("version1", op_read, version1_offset, 0, core_version[63:32]);
    add_entry("status idle", op_read, status_offset, 0, 32'h1);
    add_entry("ctrl idle", op_read, ctrl_offset, 0, 32'h0);
    add_entry("irq idle", op_check_irq, 0, 0, 32'h0);
    add_entry("busy idle", op_check_busy, 0, 0, 32'h0);
    // 512 mode, key never reads back
    load_key("t2");
    load_block("t2");
    start_op("t2 init", go_init_512);
    compute_tag(1'b0, mode_512);
    add_tag_reads("t2", tag_dwords);
    for (int i = 0; i < key_dwords; i++) begin
      add_entry($sformatf("t2 key rd%0d", i), op_read, key_base + i * 4, 0, 32'h0);
    end
    // 384 mode, init then next over a new block
    load_key("t3");
    load_block("t3");
    start_op("t3 init", go_init_384);
    compute_tag(1'b0, mode_384);
    load_block("t3 next");
    start_op("t3 next", go_next_384);
    compute_tag(1'b1, mode_384);
    add_tag_reads("t3", dwords_384);
    // mode flip while busy is dropped
    load_key("t4");
    load_block("t4");
    add_entry("t4 init", op_write, ctrl_offset, go_init_512, 0);
    add_entry("t4 busy", op_wait_busy, status_offset, 0, 0);
    add_entry("t4 mode flip", op_write, ctrl_offset, 32'h0, 0);
    add_entry("t4 valid", op_wait_valid, status_offset, 0, 0);
    add_entry("t4 status", op_read, status_offset, 0, 32'h3);
    add_entry("t4 ctrl", op_read, ctrl_offset, 0, 32'h8);
    compute_tag(1'b0, mode_512);
    add_tag_reads("t4", tag_dwords);
    // interrupts, enabled then disabled
    add_entry("t5 clr", op_write, intr_sts_offset, 32'h1, 0);
    add_entry("t5 sts clr", op_read, intr_sts_offset, 0, 32'h0);
    add_entry("t5 en", op_write, intr_en_offset, 32'h1, 0);
    start_op("t5 init en", go_init_512);
    add_entry("t5 sts set", op_read, intr_sts_offset, 0, 32'h1);
    add_entry("t5 irq high", op_check_irq, 0, 0, 32'h1);
    add_entry("t5 glb high", op_read, intr_glb_offset, 0, 32'h1);
    add_entry("t5 w1c", op_write, intr_sts_offset, 32'h1, 0);
    add_entry("t5 sts w1c", op_read, intr_sts_offset, 0, 32'h0);
    add_entry("t5 irq low", op_check_irq, 0, 0, 32'h0);
    add_entry("t5 dis", op_write, intr_en_offset, 32'h0, 0);
    start_op("t5 init dis", go_init_512);
    add_entry("t5 sts masked", op_read, intr_sts_offset, 0, 32'h1);
    add_entry("t5 irq masked", op_check_irq, 0, 0, 32'h0);
    // zeroize after a finished operation
    for (int i = 0; i < seed_dwords; i++) begin
      seed_val[i] = $random(seed);
      add_entry($sformatf("t6 seed%0d", i), op_write, seed_base + i * 4, seed_val[i], 0);
    end
    add_entry("t6 seed rd", op_read, seed_base, 0, seed_val[0]);
    add_entry("t6 zeroize", op_write, ctrl_offset, go_zeroize, 0);
    cur_w = '{default: '0};
    add_tag_reads("t6", 0);
    for (int i = 0; i < block_dwords; i++) begin
      add_entry($sformatf("t6 blk rd%0d", i), op_read, block_base + i * 4, 0, 32'h0);
    end
    for (int i = 0; i < seed_dwords; i++) begin
      add_entry($sformatf("t6 seed rd%0d", i), op_read, seed_base + i * 4, 0, 32'h0);
    end
    add_entry("t6 status", op_read, status_offset, 0, 32'h1);
    add_entry("t6 intr sts", op_read, intr_sts_offset, 0, 32'h0);
    add_entry("t6 ctrl", op_read, ctrl_offset, 0, 32'h0);
  endfunction

  // --------------------------------------------------
  // host bus
  // --------------------------------------------------
  // one idle cycle after each write
  task automatic write_reg(input logic [reg_addr_width-1:0] addr, input dword_t data);
    cs         = 1'b1;
    we         = 1'b1;
    address    = 32'(addr);
    write_data = data;
    @(posedge clk);
    #2;
    cs = 1'b0;
    we = 1'b0;
    @(posedge clk);
    #2;
  endtask

  task automatic read_reg(input logic [reg_addr_width-1:0] addr, output dword_t data);
    cs      = 1'b1;
    we      = 1'b0;
    address = 32'(addr);
    @(posedge clk);
    #2;
    cs   = 1'b0;
    data = read_data;
  endtask

  initial begin
    entry_t e;
    dword_t actual;
    bit     check;
    cs         = 1'b0;
    we         = 1'b0;
    address    = '0;
    write_data = '0;
    reset_n    = 1'b0;
    seed       = 32'h7ba3;
    build_table();
    table_done = 1'b1;
    repeat (10) @(posedge clk);
    #2;
    reset_n = 1'b1;
    for (int n = 0; n < ent_q.size(); n++) begin
      e      = ent_q[n];
      check  = 1'b0;
      actual = '0;
      case (e.op)
        op_write: write_reg(e.addr, e.data);
        op_read: begin
          read_reg(e.addr, actual);
          check = 1'b1;
        end
        op_wait_busy: begin
          actual = '1;
          while (actual[status_ready_bit]) read_reg(status_offset, actual);
        end
        op_wait_valid: begin
          while (!actual[status_valid_bit]) read_reg(status_offset, actual);
        end
        op_check_irq: begin
          actual = {31'b0, notif_intr};
          check  = 1'b1;
        end
        op_check_busy: begin
          actual = {31'b0, busy};
          check  = 1'b1;
        end
        default: ;
      endcase
      if (check) begin
        assert (actual === e.exp) else begin
          $display("ERROR: %s expected %h actual %h", name_q[n], e.exp, actual);
          $display("tests failed");
          $fatal(1);
        end
      end
    end
    $display("all tests passed");
    $finish;
  end

  // watchdog, 64 clocks per table entry
  initial begin
    wait (table_done);
    repeat (ent_q.size() * 64) @(posedge clk);
    $display("run timed out waiting for the DUT");
    $display("tests failed");
    $fatal(1);
  end

endmodule

//--- list.f
source/hmac_param_pkg.sv
source/hmac_reg_pkg.sv
source/hmac_reg_file.sv
source/hmac_msg_store.sv
source/hmac_tag_capture.sv
source/hmac_intr.sv
source/hmac_wrapper.sv
tests/hmac_core_model.sv
tests/hmac_wrapper_tb.sv
